//--- tb.f
+incdir+verilog
verilog/core_pkg.sv
verilog/pipe_ctrl_if.sv
verilog/stage_reg.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/exe_stage.sv
verilog/control_unit.sv
verilog/core_top.sv
dv/imem_model.sv
dv/tb_core.sv

//--- dv/tb_core.sv
/*
 * Core testbench: clock, reset, program load, in-order reference model
 * Commit port checked by assertions against the reference
 */
`timescale 1ns/1ns
`include "core_macros.svh"

module tb_core;

    localparam int                    PROG_LEN  = 28;
    localparam int                    MEM_WORDS = 64;
    localparam int                    TIMEOUT   = 2000;
    // Word 27 is the last instruction
    localparam logic [`CORE_XLEN-1:0] FINAL_PC  = 32'd108;

    // Starts low without an edge at time zero
    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    logic                  imem_req_valid;
    logic [`CORE_XLEN-1:0] imem_req_addr;
    logic                  imem_resp_valid;
    logic [`CORE_XLEN-1:0] imem_resp_data;
    logic                  commit_valid_o;
    logic [`CORE_XLEN-1:0] commit_pc_o;
    logic [4:0]            commit_rd_o;
    logic                  commit_we_o;
    logic [`CORE_XLEN-1:0] commit_data_o;
    logic                  commit_xcpt_o;

    logic [`CORE_XLEN-1:0] prog [PROG_LEN];
    // Architectural state of the reference
    logic [`CORE_XLEN-1:0] ref_regs [32];
    logic [`CORE_XLEN-1:0] ref_pc;
    logic                  done;
    int                    errors;
    int                    commits;
    int                    cycles;

    core_top dut0 (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .imem_req_valid_o  (imem_req_valid),
        .imem_req_addr_o   (imem_req_addr),
        .imem_resp_valid_i (imem_resp_valid),
        .imem_resp_data_i  (imem_resp_data),
        .commit_valid_o    (commit_valid_o),
        .commit_pc_o       (commit_pc_o),
        .commit_rd_o       (commit_rd_o),
        .commit_we_o       (commit_we_o),
        .commit_data_o     (commit_data_o),
        .commit_xcpt_o     (commit_xcpt_o)
    );

    imem_model #(.DEPTH(MEM_WORDS), .SEED(5)) imem0 (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (imem_req_valid),
        .req_addr_i   (imem_req_addr),
        .resp_valid_o (imem_resp_valid),
        .resp_data_o  (imem_resp_data)
    );

    always #4 clk_i = ~clk_i;

    // RV32I encoders
    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic load_program();
        prog[0]  = lui(5'd1, 20'h12345);
        prog[1]  = addi(5'd2, 5'd0, 12'd5);
        prog[2]  = addi(5'd3, 5'd0, 12'hffd);
        // Chains of dependent ALU ops
        prog[3]  = alu_rr(7'h00, 3'b000, 5'd4, 5'd2, 5'd3);
        prog[4]  = alu_rr(7'h20, 3'b000, 5'd5, 5'd4, 5'd2);
        prog[5]  = alu_rr(7'h00, 3'b111, 5'd6, 5'd1, 5'd3);
        prog[6]  = alu_rr(7'h00, 3'b110, 5'd7, 5'd2, 5'd1);
        prog[7]  = alu_rr(7'h00, 3'b100, 5'd8, 5'd5, 5'd3);
        prog[8]  = alu_rr(7'h00, 3'b010, 5'd9, 5'd3, 5'd2);
        prog[9]  = alu_rr(7'h00, 3'b010, 5'd10, 5'd2, 5'd3);
        // x0 write, then x0 read
        prog[10] = addi(5'd0, 5'd0, 12'd7);
        prog[11] = alu_rr(7'h00, 3'b000, 5'd11, 5'd0, 5'd2);
        // Untaken, then taken branches
        prog[12] = branch(3'b000, 5'd2, 5'd4, 13'd8);
        prog[13] = branch(3'b001, 5'd2, 5'd2, 13'd8);
        prog[14] = branch(3'b000, 5'd4, 5'd4, 13'd12);
        prog[15] = addi(5'd12, 5'd0, 12'd99);
        prog[16] = addi(5'd12, 5'd0, 12'd98);
        prog[17] = branch(3'b001, 5'd2, 5'd4, 13'd8);
        prog[18] = addi(5'd13, 5'd0, 12'd77);
        prog[19] = jal(5'd14, 21'd12);
        prog[20] = addi(5'd13, 5'd0, 12'd66);
        prog[21] = addi(5'd13, 5'd0, 12'd55);
        // Unsupported opcode
        prog[22] = 32'hffff_ffff;
        prog[23] = alu_rr(7'h00, 3'b000, 5'd15, 5'd14, 5'd9);
        prog[24] = addi(5'd16, 5'd15, 12'd1);
        prog[25] = branch(3'b000, 5'd0, 5'd0, 13'd8);
        prog[26] = addi(5'd17, 5'd0, 12'd44);
        prog[27] = addi(5'd17, 5'd16, 12'hf9c);
        // Unused words hold ADDI x0 with the word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem0.mem[i] = (i < PROG_LEN) ? prog[i] : addi(5'd0, 5'd0, 12'(i));
        end
    endtask

    // One instruction of the in-order reference
    task automatic ref_execute(input logic [31:0] instr, input logic [31:0] pc,
                               output logic we, output logic [4:0] rd,
                               output logic [31:0] data, output logic xcpt,
                               output logic [31:0] next_pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        a       = ref_regs[instr[19:15]];
        b       = ref_regs[instr[24:20]];
        f3      = instr[14:12];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        we      = 1'b0;
        xcpt    = 1'b0;
        data    = '0;
        rd      = instr[11:7];
        next_pc = pc + 32'd4;
        case (instr[6:0])
            7'h37: begin
                we   = 1'b1;
                data = {instr[31:12], 12'b0};
            end
            7'h13: begin
                we   = (f3 == 3'b000);
                xcpt = (f3 != 3'b000);
                data = a + imm_i;
            end
            7'h33: begin
                we = 1'b1;
                case ({instr[31:25], f3})
                    10'b0000000_000: data = a + b;
                    10'b0100000_000: data = a - b;
                    10'b0000000_111: data = a & b;
                    10'b0000000_110: data = a | b;
                    10'b0000000_100: data = a ^ b;
                    10'b0000000_010: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: begin
                        we   = 1'b0;
                        xcpt = 1'b1;
                    end
                endcase
            end
            7'h63: begin
                if (f3 == 3'b000 || f3 == 3'b001) begin
                    // BEQ on equal, BNE on not equal
                    if ((a == b) == (f3 == 3'b000)) begin
                        next_pc = pc + imm_b;
                    end
                end else begin
                    xcpt = 1'b1;
                end
            end
            7'h6f: begin
                we      = 1'b1;
                data    = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            default: xcpt = 1'b1;
        endcase
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic check_commit();
        logic [31:0] instr;
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        exp_xcpt;
        logic [31:0] exp_next;
        instr = (ref_pc[31:2] < PROG_LEN) ? prog[ref_pc[31:2]] : 32'h0;
        ref_execute(instr, ref_pc, exp_we, exp_rd, exp_data, exp_xcpt, exp_next);
        commits++;
        // A wrong-path commit shows up as a pc mismatch
        assert (commit_pc_o == ref_pc) else report_mismatch("commit pc", commit_pc_o, ref_pc);
        assert (commit_xcpt_o == exp_xcpt)
            else report_mismatch("commit xcpt", commit_xcpt_o, exp_xcpt);
        assert (commit_we_o == exp_we) else report_mismatch("commit we", commit_we_o, exp_we);
        if (exp_we) begin
            assert (commit_rd_o == exp_rd)
                else report_mismatch("commit rd", commit_rd_o, exp_rd);
            assert (commit_data_o == exp_data)
                else report_mismatch("commit data", commit_data_o, exp_data);
        end
        if (exp_we && exp_rd != 5'd0) begin
            ref_regs[exp_rd] = exp_data;
        end
        if (ref_pc == FINAL_PC) begin
            done = 1'b1;
        end
        ref_pc = exp_next;
    endtask

    // Commit outputs settle after the rising edge
    always @(negedge clk_i) begin
        if (!rstn_i) begin
            assert (!commit_valid_o && !imem_req_valid) else begin
                errors++;
                $display("Error at %0t ns: commit or fetch request active in reset", $time);
            end
        end else if (!done) begin
            assert (commit_valid_o || (!commit_we_o && !commit_xcpt_o)) else begin
                errors++;
                $display("Error at %0t ns: write or exception flagged with no commit", $time);
            end
            if (commit_valid_o) begin
                check_commit();
            end
        end
    end

    initial begin
        rstn_i  = 1'b0;
        done    = 1'b0;
        errors  = 0;
        commits = 0;
        cycles  = 0;
        ref_pc  = `CORE_BOOT_PC;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        load_program();
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        // Run until the last instruction retires
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("Timeout: the final instruction did not commit in %0d cycles", TIMEOUT);
        end
        $display("Summary: %0d commits checked, %0d errors", commits, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- dv/imem_model.sv
/*
 * Instruction memory model for the fetch port
 * One request at a time, answered after 1 to 4 cycles
 */
`timescale 1ns/1ns
`include "core_macros.svh"

module imem_model #(
    parameter int DEPTH = 64,
    parameter int SEED  = 5
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  req_valid_i,
    input  logic [`CORE_XLEN-1:0] req_addr_i,
    output logic                  resp_valid_o,
    output logic [`CORE_XLEN-1:0] resp_data_o
);

    // Word array, loaded by the testbench before reset release
    logic [`CORE_XLEN-1:0] mem [DEPTH];
    logic [`CORE_XLEN-1:0] addr_q;
    logic                  busy_q;
    int                    cnt_q;
    int                    lat;
    integer                seed;

    initial seed = SEED;

    // Byte address to word slot
    function automatic int word_index(input logic [`CORE_XLEN-1:0] addr);
        return (addr >> 2) % DEPTH;
    endfunction

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_valid_o <= 1'b0;
            resp_data_o  <= '0;
            addr_q       <= '0;
            busy_q       <= 1'b0;
            cnt_q        <= 0;
        end else begin
            resp_valid_o <= 1'b0;
            if (req_valid_i) begin
                lat = 1 + ($unsigned($random(seed)) % 4);
                // Latency of one answers in the very next cycle
                if (lat == 1) begin
                    resp_valid_o <= 1'b1;
                    resp_data_o  <= mem[word_index(req_addr_i)];
                end else begin
                    busy_q <= 1'b1;
                    addr_q <= req_addr_i;
                    cnt_q  <= lat - 1;
                end
            end else if (busy_q) begin
                if (cnt_q == 1) begin
                    resp_valid_o <= 1'b1;
                    resp_data_o  <= mem[word_index(addr_q)];
                    busy_q       <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 1;
                end
            end
        end
    end

endmodule

//--- verilog/core_top.sv
/*
 * Core top: stages, stage registers, control unit, commit port
 */
`timescale 1ns/1ns
`include "core_macros.svh"

module core_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // Instruction fetch
    output logic                          imem_req_valid_o,
    output logic [`CORE_XLEN-1:0]          imem_req_addr_o,
    input  logic                          imem_resp_valid_i,
    input  logic [`CORE_XLEN-1:0]          imem_resp_data_i,
    // Retired instruction
    output logic                          commit_valid_o,
    output logic [`CORE_XLEN-1:0]          commit_pc_o,
    output logic [$clog2(`CORE_NREGS)-1:0] commit_rd_o,
    output logic                          commit_we_o,
    output logic [`CORE_XLEN-1:0]          commit_data_o,
    output logic                          commit_xcpt_o
);
    import core_pkg::*;

    if_id_t  fetch_d;
    if_id_t  if_id_q;
    id_exe_t id_exe_d;
    id_exe_t id_exe_q;
    exe_wb_t exe_wb_d;
    exe_wb_t exe_wb_q;
    logic    wb_we;

    pipe_ctrl_if ctrl_if ();

    control_unit cu0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .fetch_valid_i (fetch_d.valid),
        .ctrl          (ctrl_if.cu)
    );

    fetch_stage if0 (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .ctrl              (ctrl_if.fetch),
        .imem_req_valid_o  (imem_req_valid_o),
        .imem_req_addr_o   (imem_req_addr_o),
        .imem_resp_valid_i (imem_resp_valid_i),
        .imem_resp_data_i  (imem_resp_data_i),
        .fetch_o           (fetch_d)
    );

    // Stalled fetch loads an empty slot
    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (ctrl_if.flush_if || ctrl_if.stall_if),
        .load_i  (!ctrl_if.stall_if),
        .data_i  (fetch_d),
        .data_o  (if_id_q)
    );

    decode_stage id0 (
        .clk_i     (clk_i),
        .decode_i  (if_id_q),
        .wb_we_i   (wb_we),
        .wb_rd_i   (exe_wb_q.rd),
        .wb_data_i (exe_wb_q.result),
        .decode_o  (id_exe_d)
    );

    stage_reg #(.payload_t(id_exe_t)) id_exe_reg (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (ctrl_if.flush_id),
        .load_i  (1'b1),
        .data_i  (id_exe_d),
        .data_o  (id_exe_q)
    );

    exe_stage ex0 (
        .exe_i (id_exe_q),
        .wb_i  (exe_wb_q),
        .ctrl  (ctrl_if.exe),
        .exe_o (exe_wb_d)
    );

    // Nothing downstream of execute is ever killed
    stage_reg #(.payload_t(exe_wb_t)) exe_wb_reg (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (1'b0),
        .load_i  (1'b1),
        .data_i  (exe_wb_d),
        .data_o  (exe_wb_q)
    );

    // Illegal instructions retire without a register write
    assign wb_we = exe_wb_q.valid && exe_wb_q.rf_we && !exe_wb_q.illegal;

    assign commit_valid_o = exe_wb_q.valid;
    assign commit_pc_o    = exe_wb_q.pc;
    assign commit_rd_o    = exe_wb_q.rd;
    assign commit_we_o    = wb_we;
    assign commit_data_o  = exe_wb_q.result;
    assign commit_xcpt_o  = exe_wb_q.valid && exe_wb_q.illegal;

endmodule

//--- verilog/control_unit.sv
/*
 * Control unit: fetch stall, redirect flushes, next-PC select
 */
`timescale 1ns/1ns

module control_unit (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    fetch_valid_i,
    pipe_ctrl_if.cu ctrl
);
    import core_pkg::*;

    // Redirect from last cycle, fetch slot still on the old path
    logic redir_pend_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            redir_pend_q <= 1'b0;
        end else begin
            redir_pend_q <= ctrl.redirect;
        end
    end

    // Bubble into IF/ID while fetch has nothing kept
    assign ctrl.stall_if = !fetch_valid_i;

    // IF/ID kept clear one extra cycle after the redirect
    assign ctrl.flush_if = ctrl.redirect || redir_pend_q;

    // ID/EXE only holds wrong-path work in the redirect cycle
    assign ctrl.flush_id = ctrl.redirect;

    // PC loads the target on the redirect edge
    assign ctrl.next_pc = ctrl.redirect ? NEXT_PC_REDIRECT : NEXT_PC_SEQ;

    // Flushes only follow a taken branch or jump
    a_flush_cause : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ctrl.flush_if || ctrl.flush_id) |-> (ctrl.redirect || $past(ctrl.redirect)));

endmodule

//--- verilog/exe_stage.sv
/*
 * Execute: write-back bypass, ALU, branch and jump resolution
 */
`timescale 1ns/1ns

module exe_stage (
    input  core_pkg::id_exe_t exe_i,
    input  core_pkg::exe_wb_t wb_i,
    pipe_ctrl_if.exe          ctrl,
    output core_pkg::exe_wb_t exe_o
);
    import core_pkg::*;

    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_res;
    logic  taken;

    // Take the WB result for a matching nonzero source
    function automatic word_t bypass(input exe_wb_t wb, input reg_idx_t src,
                                     input word_t rf_val);
        if (wb.valid && wb.rf_we && (wb.rd != '0) && (wb.rd == src)) begin
            return wb.result;
        end
        return rf_val;
    endfunction

    assign op_a    = bypass(wb_i, exe_i.rs1, exe_i.rs1_data);
    assign rs2_val = bypass(wb_i, exe_i.rs2, exe_i.rs2_data);
    assign op_b    = exe_i.use_imm ? exe_i.imm : rs2_val;

    always_comb begin
        case (exe_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            // Signed compare
            ALU_SLT:    alu_res = {{($bits(word_t)-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branch compare on register values, not the ALU B input
    always_comb begin
        case (exe_i.br_type)
            BR_BEQ:  taken = (op_a == rs2_val);
            BR_BNE:  taken = (op_a != rs2_val);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign ctrl.redirect    = exe_i.valid && taken;
    assign ctrl.redirect_pc = exe_i.pc + exe_i.imm;

    assign exe_o.valid   = exe_i.valid;
    assign exe_o.pc      = exe_i.pc;
    assign exe_o.rd      = exe_i.rd;
    assign exe_o.rf_we   = exe_i.rf_we;
    // JAL links pc+4
    assign exe_o.result  = (exe_i.br_type == BR_JAL) ? exe_i.pc + 4 : alu_res;
    assign exe_o.illegal = exe_i.illegal;

endmodule

//--- verilog/decode_stage.sv
/*
 * Decode: field split, immediates, illegal-encoding check, register read
 */
`timescale 1ns/1ns
`include "core_macros.svh"

module decode_stage (
    input  logic                  clk_i,
    input  core_pkg::if_id_t      decode_i,
    input  logic                  wb_we_i,
    input  core_pkg::reg_idx_t    wb_rd_i,
    input  logic [`CORE_XLEN-1:0] wb_data_i,
    output core_pkg::id_exe_t     decode_o
);
    import core_pkg::*;

    word_t      instr;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      rs1_data;
    word_t      rs2_data;

    // Bubbles decode as NOP
    assign instr  = decode_i.valid ? decode_i.instr : `CORE_NOP;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Write-back port writes through to these reads
    regfile rf0 (
        .clk_i      (clk_i),
        .rd_addr1_i (instr[19:15]),
        .rd_addr2_i (instr[24:20]),
        .rd_data1_o (rs1_data),
        .rd_data2_o (rs2_data),
        .we_i       (wb_we_i),
        .wr_addr_i  (wb_rd_i),
        .wr_data_i  (wb_data_i)
    );

    always_comb begin
        decode_o          = '0;
        decode_o.valid    = decode_i.valid;
        decode_o.pc       = decode_i.pc;
        decode_o.rs1      = instr[19:15];
        decode_o.rs2      = instr[24:20];
        decode_o.rs1_data = rs1_data;
        decode_o.rs2_data = rs2_data;
        decode_o.rd       = instr[11:7];
        decode_o.alu_op   = ALU_ADD;
        decode_o.br_type  = BR_NONE;
        case (instr[6:0])
            OP_LUI: begin
                decode_o.imm     = imm_u;
                decode_o.use_imm = 1'b1;
                decode_o.alu_op  = ALU_PASS_B;
                decode_o.rf_we   = 1'b1;
            end
            // ADDI only
            OP_IMM: begin
                decode_o.imm     = imm_i;
                decode_o.use_imm = 1'b1;
                decode_o.rf_we   = (funct3 == 3'b000);
                decode_o.illegal = (funct3 != 3'b000);
            end
            OP_REG: begin
                decode_o.rf_we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: decode_o.alu_op = ALU_ADD;
                    10'b0100000_000: decode_o.alu_op = ALU_SUB;
                    10'b0000000_111: decode_o.alu_op = ALU_AND;
                    10'b0000000_110: decode_o.alu_op = ALU_OR;
                    10'b0000000_100: decode_o.alu_op = ALU_XOR;
                    10'b0000000_010: decode_o.alu_op = ALU_SLT;
                    default: begin
                        decode_o.rf_we   = 1'b0;
                        decode_o.illegal = 1'b1;
                    end
                endcase
            end
            // BEQ and BNE, no register write
            OP_BRANCH: begin
                decode_o.imm = imm_b;
                case (funct3)
                    3'b000:  decode_o.br_type = BR_BEQ;
                    3'b001:  decode_o.br_type = BR_BNE;
                    default: decode_o.illegal = 1'b1;
                endcase
            end
            OP_JAL: begin
                decode_o.imm     = imm_j;
                decode_o.br_type = BR_JAL;
                decode_o.rf_we   = 1'b1;
            end
            default: decode_o.illegal = 1'b1;
        endcase
    end

endmodule

//--- verilog/regfile.sv
/*
 * Integer register file, two read ports and one write port
 * x0 hardwired to zero, same-cycle write visible on reads
 */
`timescale 1ns/1ns
`include "core_macros.svh"

module regfile (
    input  logic                          clk_i,
    input  logic [$clog2(`CORE_NREGS)-1:0] rd_addr1_i,
    input  logic [$clog2(`CORE_NREGS)-1:0] rd_addr2_i,
    output logic [`CORE_XLEN-1:0]          rd_data1_o,
    output logic [`CORE_XLEN-1:0]          rd_data2_o,
    input  logic                          we_i,
    input  logic [$clog2(`CORE_NREGS)-1:0] wr_addr_i,
    input  logic [`CORE_XLEN-1:0]          wr_data_i
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_NREGS];

    // Entry 0 never written
    always_ff @(posedge clk_i) begin
        if (we_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Zero first, then write-through, then array
    assign rd_data1_o = (rd_addr1_i == '0) ? '0 :
                        (we_i && (wr_addr_i == rd_addr1_i)) ? wr_data_i :
                        regs_q[rd_addr1_i];

    assign rd_data2_o = (rd_addr2_i == '0) ? '0 :
                        (we_i && (wr_addr_i == rd_addr2_i)) ? wr_data_i :
                        regs_q[rd_addr2_i];

endmodule

//--- verilog/fetch_stage.sv
/*
 * Fetch: PC, one-deep request tracking, drop of wrong-path responses
 */
`timescale 1ns/1ns
`include "core_macros.svh"

module fetch_stage (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    pipe_ctrl_if.fetch            ctrl,
    output logic                  imem_req_valid_o,
    output logic [`CORE_XLEN-1:0] imem_req_addr_o,
    input  logic                  imem_resp_valid_i,
    input  logic [`CORE_XLEN-1:0] imem_resp_data_i,
    output core_pkg::if_id_t      fetch_o
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] pc_q;
    // Low until the first edge out of reset
    logic                  boot_q;
    logic                  busy_q;
    // In-flight response belongs to the old path
    logic                  drop_q;
    logic                  busy_d;
    logic                  redir;

    assign redir = (ctrl.next_pc == NEXT_PC_REDIRECT);

    // New request only when nothing is in flight
    assign imem_req_valid_o = boot_q && !busy_q;
    assign imem_req_addr_o  = pc_q;

    // Request and response never share a cycle
    assign busy_d = imem_req_valid_o || (busy_q && !imem_resp_valid_i);

    // PC still names the in-flight request
    assign fetch_o.valid = imem_resp_valid_i && !drop_q;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = imem_resp_data_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q   <= `CORE_BOOT_PC;
            boot_q <= 1'b0;
            busy_q <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            boot_q <= 1'b1;
            busy_q <= busy_d;
            // Anything still out after this edge is wrong-path
            if (redir) begin
                drop_q <= busy_d;
            end else if (imem_resp_valid_i) begin
                drop_q <= 1'b0;
            end
            // Redirect over sequential advance
            if (redir) begin
                pc_q <= ctrl.redirect_pc;
            end else if (!ctrl.stall_if) begin
                pc_q <= pc_q + `CORE_XLEN'd4;
            end
        end
    end

    // No second strobe before the answer to the first
    a_one_in_flight : assert property (@(posedge clk_i) disable iff (!rstn_i)
        imem_req_valid_o |=> (!imem_req_valid_o until_with imem_resp_valid_i));

endmodule

//--- verilog/stage_reg.sv
/*
 * Pipeline register with flush and load, generic over its payload type
 */
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = core_pkg::if_id_t
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     flush_i,
    input  logic     load_i,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t data_q;

    // Flush wins over load
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            data_q <= '0;
        end else if (flush_i) begin
            data_q <= '0;
        end else if (load_i) begin
            data_q <= data_i;
        end
    end

    assign data_o = data_q;

    // Killed entry must not show up downstream
    a_flush_kills : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (flush_i && load_i && data_i.valid) |=> !data_o.valid);

endmodule

//--- verilog/pipe_ctrl_if.sv
/*
 * Pipeline control bundle: stall, flushes, next-PC select, redirect target
 */
`timescale 1ns/1ns
`include "core_macros.svh"

interface pipe_ctrl_if;
    import core_pkg::*;

    // From control unit
    logic     stall_if;
    logic     flush_if;
    logic     flush_id;
    next_pc_t next_pc;

    // From execute on a taken branch or jump
    logic                  redirect;
    logic [`CORE_XLEN-1:0] redirect_pc;

    modport cu (
        output stall_if, flush_if, flush_id, next_pc,
        input  redirect
    );

    modport fetch (
        input stall_if, next_pc, redirect_pc
    );

    modport exe (
        output redirect, redirect_pc
    );

endinterface

//--- verilog/core_pkg.sv
/*
 * Opcode, ALU-op, branch-type and next-PC enums
 * Payload structs for the IF/ID, ID/EXE and EXE/WB registers
 */
`include "core_macros.svh"

package core_pkg;

    // Common widths
    typedef logic [`CORE_XLEN-1:0]          word_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

    // Major opcodes handled by the pipeline
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // Control transfer kind, resolved in execute
    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_type_t;

    // Fetch address source
    typedef enum logic {
        NEXT_PC_SEQ,
        NEXT_PC_REDIRECT
    } next_pc_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        alu_op_t  alu_op;
        // B operand from imm instead of rs2
        logic     use_imm;
        br_type_t br_type;
        reg_idx_t rd;
        logic     rf_we;
        logic     illegal;
    } id_exe_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rf_we;
        word_t    result;
        logic     illegal;
    } exe_wb_t;

endpackage

//--- verilog/core_macros.svh
/*
 * Core-wide constants: data width, register count, boot address, NOP encoding
 */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and PC width
`define CORE_XLEN 32

// Architectural integer registers
`define CORE_NREGS 32

// First fetch address after reset
`define CORE_BOOT_PC 32'h0000_0000

// ADDI x0, x0, 0
// Decode sees this in place of an empty IF/ID slot
`define CORE_NOP 32'h0000_0013

`endif
